// ==== all.f ====
+incdir+test
hw/cps_pkg.sv
hw/cps_video_timer.sv
hw/cps_mmr.sv
hw/cps_scroll_addr.sv
hw/cps_layer_order.sv
hw/cps_video_regs.sv
test/tb_cps_video_regs.sv

// ==== test/tb_checks.svh ====
/*
 * Compare tasks for each result type and the CPU bus write driver
 */

    task automatic scroll_compare(input string name, input scroll_regs_t got,
                                  input scroll_regs_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic bases_compare(input string name, input base_regs_t got,
                                 input base_regs_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic cpsb_compare(input string name, input cpsb_regs_t got,
                                input cpsb_regs_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic tile_compare(input string name, input tile_addr_t got,
                                input tile_addr_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic order_compare(input string name, input draw_order_t got,
                                 input draw_order_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic word_compare(input string name, input logic [15:0] got,
                                input logic [15:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // One strobe cycle, called 5 ns after a rising edge and returns likewise
    task automatic write_bus(input logic [4:0] addr, input logic [1:0] dsn,
                             input logic [15:0] data, input logic sel_a, input logic sel_b);
        wr.addr = addr;
        wr.dsn  = dsn;
        wr.data = data;
        ppu1_cs = sel_a;
        ppu2_cs = sel_b;
        if (sel_a) begin
            cpsa_model(addr, dsn, data);
        end
        if (sel_b) begin
            cpsb_model(addr, dsn, data);
        end
        @(posedge clk);
        #5;
        ppu1_cs = 1'b0;
        ppu2_cs = 1'b0;
        wr      = '0;
    endtask

// ==== test/tb_cps_video_regs.sv ====
/*
 * Testbench for the video register block: clock, reset, LFSR data,
 * register shadow model, directed tests and watchdog
 */
`timescale 1ns/1ns

module tb_cps_video_regs import cps_pkg::*; ();

    localparam int clk_period = 100;
    // Bus traffic of all tests, plus up to one raster line per scroll round
    localparam int bus_cycles    = 150;
    localparam int scroll_cycles = 4 * (h_total + 64);
    localparam int watchdog_ns   = (16 + bus_cycles + scroll_cycles + 200) * clk_period;

    logic         clk;
    logic         reg_rst;
    bus_wr_t      wr;
    logic         ppu1_cs;
    logic         ppu2_cs;
    cpsb_map_t    cpsb_map;
    logic [8:0]   hdump;
    logic [8:0]   vdump;
    logic         line_start;
    scroll_regs_t scroll;
    base_regs_t   bases;
    star_regs_t   stars;
    logic [15:0]  ppu_ctrl;
    cpsb_regs_t   cpsb;
    tile_addr_t   tile_addr;
    draw_order_t  order;

    // Shadow of CPS-A indexed by offset, and of CPS-B
    logic [15:0]  exp_cpsa [0:17];
    cpsb_regs_t   exp_cpsb;
    logic [31:0]  lfsr_state;
    int           errors;
    int           tests_passed;
    int           tests_failed;

    `include "tb_checks.svh"

    cps_video_regs u_cps_video_regs (
        .clk        (clk),
        .reg_rst    (reg_rst),
        .wr         (wr),
        .ppu1_cs    (ppu1_cs),
        .ppu2_cs    (ppu2_cs),
        .cpsb_map   (cpsb_map),
        .hdump      (hdump),
        .vdump      (vdump),
        .line_start (line_start),
        .scroll     (scroll),
        .bases      (bases),
        .stars      (stars),
        .ppu_ctrl   (ppu_ctrl),
        .cpsb       (cpsb),
        .tile_addr  (tile_addr),
        .order      (order)
    );

    always #(clk_period / 2) clk = ~clk;

    // Galois LFSR, one step per bit taken
    function automatic logic [15:0] rand_bits(input int nbits);
        logic [15:0] val;
        val = '0;
        for (int i = 0; i < nbits; i++) begin
            val = {val[14:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h80200003 : lfsr_state >> 1;
        end
        return val;
    endfunction

    // Strobe bit high keeps the old byte
    function automatic logic [15:0] lane_update(input logic [15:0] old,
                                                input logic [1:0] dsn, input logic [15:0] data);
        logic [15:0] keep;
        keep = {{8{dsn[1]}}, {8{dsn[0]}}};
        return (old & keep) | (data & ~keep);
    endfunction

    task automatic cpsa_model(input logic [4:0] addr, input logic [1:0] dsn,
                              input logic [15:0] data);
        if (addr <= 5'd17) begin
            exp_cpsa[addr] = lane_update(exp_cpsa[addr], dsn, data);
        end
    endtask

    task automatic cpsb_model(input logic [4:0] addr, input logic [1:0] dsn,
                              input logic [15:0] data);
        logic [15:0] pal;
        pal = lane_update({10'd0, exp_cpsb.pal_page_en}, dsn, data);
        if (addr == cpsb_map.layer) begin
            exp_cpsb.layer_ctrl = lane_update(exp_cpsb.layer_ctrl, dsn, data);
        end
        if (addr == cpsb_map.prio0) begin
            exp_cpsb.prio0 = lane_update(exp_cpsb.prio0, dsn, data);
        end
        if (addr == cpsb_map.prio1) begin
            exp_cpsb.prio1 = lane_update(exp_cpsb.prio1, dsn, data);
        end
        if (addr == cpsb_map.prio2) begin
            exp_cpsb.prio2 = lane_update(exp_cpsb.prio2, dsn, data);
        end
        if (addr == cpsb_map.prio3) begin
            exp_cpsb.prio3 = lane_update(exp_cpsb.prio3, dsn, data);
        end
        if (addr == cpsb_map.pal_page) begin
            exp_cpsb.pal_page_en = pal[5:0];
        end
    endtask

    function automatic draw_order_t order_rule(input logic [15:0] lc);
        return {lc[7:6], lc[9:8], lc[11:10], lc[13:12], lc[5:1]};
    endfunction

    function automatic logic [15:0] tile_rule(input int base, input int hpos, input int vpos,
                                              input int hd, input int vd, input int size);
        int col;
        int row;
        col = ((hd + hpos) / size) % map_tiles;
        row = ((vd + vpos) / size) % map_tiles;
        return (base + 2 * (row * map_tiles + col)) % 65536;
    endfunction

    // Every register output against the shadow
    task automatic bank_check();
        scroll_compare("scroll", scroll, {exp_cpsa[hpos1], exp_cpsa[vpos1], exp_cpsa[hpos2],
                       exp_cpsa[vpos2], exp_cpsa[hpos3], exp_cpsa[vpos3]});
        bases_compare("bases", bases, {exp_cpsa[obj_base], exp_cpsa[scr1_base],
                      exp_cpsa[scr2_base], exp_cpsa[scr3_base], exp_cpsa[row_base],
                      exp_cpsa[star_base], exp_cpsa[pal_base]});
        word_compare("hstar1", stars.hstar1, exp_cpsa[hstar1]);
        word_compare("vstar1", stars.vstar1, exp_cpsa[vstar1]);
        word_compare("hstar2", stars.hstar2, exp_cpsa[hstar2]);
        word_compare("vstar2", stars.vstar2, exp_cpsa[vstar2]);
        word_compare("ppu_ctrl", ppu_ctrl, exp_cpsa[cps_pkg::ppu_ctrl]);
        cpsb_compare("cpsb", cpsb, exp_cpsb);
    endtask

    task automatic finish_test(input string name, input int errs_at_start);
        if (errors == errs_at_start) begin
            tests_passed++;
            $display("Test %s passed", name);
        end else begin
            tests_failed++;
            $display("Test %s failed with %0d errors", name, errors - errs_at_start);
        end
    endtask

    // Runs while reset is still held
    task automatic reset_values();
        int e0;
        e0 = errors;
        bank_check();
        tile_compare("tile_addr", tile_addr, '0);
        order_compare("order", order, '0);
        word_compare("hdump", 16'(hdump), 16'h0000);
        word_compare("vdump", 16'(vdump), 16'h0000);
        word_compare("line_start", 16'(line_start), 16'h0000);
        finish_test("reset_values", e0);
    endtask

    task automatic cpsa_writes();
        int e0;
        e0 = errors;
        for (int a = 0; a <= 17; a++) begin
            write_bus(5'(a), 2'b00, rand_bits(16), 1'b1, 1'b0);
            bank_check();
        end
        // Unmapped offsets
        write_bus(5'h12, 2'b00, rand_bits(16), 1'b1, 1'b0);
        bank_check();
        write_bus(5'h1f, 2'b00, rand_bits(16), 1'b1, 1'b0);
        bank_check();
        finish_test("cpsa_writes", e0);
    endtask

    task automatic byte_lanes();
        logic [1:0] lanes [3];
        int e0;
        lanes = '{2'b10, 2'b01, 2'b11};
        e0 = errors;
        foreach (lanes[i]) begin
            write_bus(hpos2, lanes[i], rand_bits(16), 1'b1, 1'b0);
            bank_check();
            write_bus(cpsb_map.prio1, lanes[i], rand_bits(16), 1'b0, 1'b1);
            bank_check();
            write_bus(cpsb_map.pal_page, lanes[i], rand_bits(16), 1'b0, 1'b1);
            bank_check();
        end
        finish_test("byte_lanes", e0);
    endtask

    // prio0 and prio1 share one offset, others overlap CPS-A offsets
    task automatic cpsb_mapping();
        int e0;
        e0 = errors;
        cpsb_map = '{layer: 5'h03, prio0: 5'h08, prio1: 5'h08, prio2: 5'h1a,
                     prio3: 5'h1c, pal_page: 5'h11};
        for (int a = 0; a < 32; a++) begin
            write_bus(5'(a), 2'b00, rand_bits(16), 1'b0, 1'b1);
            bank_check();
        end
        write_bus(5'h08, 2'b00, rand_bits(16), 1'b1, 1'b1);
        bank_check();
        finish_test("cpsb_mapping", e0);
    endtask

    task automatic scroll_address();
        logic [8:0] hd;
        logic [8:0] vd;
        int         hd_next;
        int         vd_next;
        tile_addr_t exp;
        int         e0;
        e0 = errors;
        for (int r = 0; r < 4; r++) begin
            for (int a = 1; a <= 3; a++) write_bus(5'(a), 2'b00, rand_bits(16), 1'b1, 1'b0);
            for (int a = 6; a <= 11; a++) write_bus(5'(a), 2'b00, rand_bits(16), 1'b1, 1'b0);
            for (int s = 0; s < 4; s++) begin
                // Last sample of a round lands on the line wrap
                if (s == 3) begin
                    while (hdump != 9'(h_total - 1)) begin
                        @(posedge clk);
                        #5;
                    end
                end else begin
                    repeat (rand_bits(3)) begin
                        @(posedge clk);
                        #5;
                    end
                end
                hd = hdump;
                vd = vdump;
                @(posedge clk);
                #5;
                exp.scr1 = tile_rule(exp_cpsa[scr1_base], exp_cpsa[hpos1], exp_cpsa[vpos1],
                                     hd, vd, 8);
                exp.scr2 = tile_rule(exp_cpsa[scr2_base], exp_cpsa[hpos2], exp_cpsa[vpos2],
                                     hd, vd, 16);
                exp.scr3 = tile_rule(exp_cpsa[scr3_base], exp_cpsa[hpos3], exp_cpsa[vpos3],
                                     hd, vd, 32);
                tile_compare("tile_addr", tile_addr, exp);
                hd_next = (hd + 1) % h_total;
                vd_next = (hd == h_total - 1) ? (vd + 1) % v_total : vd;
                word_compare("hdump", 16'(hdump), 16'(hd_next));
                word_compare("vdump", 16'(vdump), 16'(vd_next));
                word_compare("line_start", 16'(line_start), 16'(hd_next == 0));
            end
        end
        finish_test("scroll_address", e0);
    endtask

    task automatic layer_order_decode();
        draw_order_t prev;
        int          e0;
        e0 = errors;
        for (int n = 0; n < 6; n++) begin
            prev = order_rule(exp_cpsb.layer_ctrl);
            write_bus(cpsb_map.layer, 2'b00, rand_bits(16), 1'b0, 1'b1);
            order_compare("order", order, prev);
            @(posedge clk);
            #5;
            order_compare("order", order, order_rule(exp_cpsb.layer_ctrl));
        end
        finish_test("layer_order_decode", e0);
    endtask

    initial begin
        clk          = 1'b0;
        reg_rst      = 1'b1;
        wr           = '0;
        ppu1_cs      = 1'b0;
        ppu2_cs      = 1'b0;
        cpsb_map     = '{layer: 5'h12, prio0: 5'h13, prio1: 5'h14, prio2: 5'h15,
                         prio3: 5'h16, pal_page: 5'h17};
        lfsr_state   = 32'h70cdbbea;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        foreach (exp_cpsa[i]) exp_cpsa[i] = '0;
        exp_cpsb = '{layer_ctrl: 16'h0000, prio0: 16'hffff, prio1: 16'hffff,
                     prio2: 16'hffff, prio3: 16'hffff, pal_page_en: 6'h3f};
        repeat (16) @(posedge clk);
        #5;
        reset_values();
        reg_rst = 1'b0;
        cpsa_writes();
        byte_lanes();
        cpsb_mapping();
        scroll_address();
        layer_order_decode();
        $display("Tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(watchdog_ns);
        $display("Timeout: tests still running after %0d ns", watchdog_ns);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

// ==== hw/cps_video_regs.sv ====
/*
 * Video register block top: raster timer, register banks,
 * scroll address unit and layer order decoder
 */
`timescale 1ns/1ns

module cps_video_regs import cps_pkg::*; (
    input  logic         clk,
    input  logic         reg_rst,
    input  bus_wr_t      wr,
    input  logic         ppu1_cs,
    input  logic         ppu2_cs,
    input  cpsb_map_t    cpsb_map,
    output logic [8:0]   hdump,
    output logic [8:0]   vdump,
    output logic         line_start,
    output scroll_regs_t scroll,
    output base_regs_t   bases,
    output star_regs_t   stars,
    output logic [15:0]  ppu_ctrl,
    output cpsb_regs_t   cpsb,
    output tile_addr_t   tile_addr,
    output draw_order_t  order
);

    cps_video_timer u_timer (
        .clk        (clk),
        .reg_rst    (reg_rst),
        .hdump      (hdump),
        .vdump      (vdump),
        .line_start (line_start)
    );

    cps_mmr u_mmr (
        .clk      (clk),
        .reg_rst  (reg_rst),
        .wr       (wr),
        .ppu1_cs  (ppu1_cs),
        .ppu2_cs  (ppu2_cs),
        .cpsb_map (cpsb_map),
        .scroll   (scroll),
        .bases    (bases),
        .stars    (stars),
        .ppu_ctrl (ppu_ctrl),
        .cpsb     (cpsb)
    );

    // Video-side consumers of the buffered registers
    cps_scroll_addr u_scroll (
        .clk       (clk),
        .reg_rst   (reg_rst),
        .hdump     (hdump),
        .vdump     (vdump),
        .scroll    (scroll),
        .bases     (bases),
        .tile_addr (tile_addr)
    );

    cps_layer_order u_order (
        .clk        (clk),
        .reg_rst    (reg_rst),
        .layer_ctrl (cpsb.layer_ctrl),
        .order      (order)
    );

endmodule

// ==== hw/cps_layer_order.sv ====
/*
 * Registered decode of the layer control word into draw order
 * and layer enables
 */
`timescale 1ns/1ns

module cps_layer_order import cps_pkg::*; (
    input  logic        clk,
    input  logic        reg_rst,
    input  logic [15:0] layer_ctrl,
    output draw_order_t order
);

    draw_order_t next_order;

    // Two bits per slot from bit 6 upward, first drawn in the lowest pair
    always_comb begin
        next_order.draw0 = layer_id_t'(layer_ctrl[7:6]);
        next_order.draw1 = layer_id_t'(layer_ctrl[9:8]);
        next_order.draw2 = layer_id_t'(layer_ctrl[11:10]);
        next_order.draw3 = layer_id_t'(layer_ctrl[13:12]);
        // Layer enables sit just below the order fields
        next_order.en    = layer_ctrl[5:1];
    end

    always_ff @(posedge clk or posedge reg_rst) begin
        if (reg_rst) begin
            order <= '0;
        end else begin
            order <= next_order;
        end
    end

endmodule

// ==== hw/cps_scroll_addr.sv ====
/*
 * Registered tile map word addresses for the three scroll layers
 * at the current screen position
 */
`timescale 1ns/1ns

module cps_scroll_addr import cps_pkg::*; (
    input  logic         clk,
    input  logic         reg_rst,
    input  logic [8:0]   hdump,
    input  logic [8:0]   vdump,
    input  scroll_regs_t scroll,
    input  base_regs_t   bases,
    output tile_addr_t   tile_addr
);

    // Word address of the map entry under one scrolled point.
    // Column and row wrap on the map edge, the sum wraps at 64K words
    function automatic logic [15:0] map_addr(
        input logic [15:0] base,
        input logic [15:0] hpix,
        input logic [15:0] vpix,
        input int          tile_shift
    );
        logic [15:0] col;
        logic [15:0] row;
        logic [15:0] entry;
        col   = (hpix >> tile_shift) & 16'(map_tiles - 1);
        row   = (vpix >> tile_shift) & 16'(map_tiles - 1);
        entry = row * 16'(map_tiles) + col;
        return base + (entry << 1);
    endfunction

    // Scrolled pixel position per layer
    logic [15:0] h1;
    logic [15:0] v1;
    logic [15:0] h2;
    logic [15:0] v2;
    logic [15:0] h3;
    logic [15:0] v3;

    assign h1 = {7'd0, hdump} + scroll.hpos1;
    assign v1 = {7'd0, vdump} + scroll.vpos1;
    assign h2 = {7'd0, hdump} + scroll.hpos2;
    assign v2 = {7'd0, vdump} + scroll.vpos2;
    assign h3 = {7'd0, hdump} + scroll.hpos3;
    assign v3 = {7'd0, vdump} + scroll.vpos3;

    // Tile sizes 8, 16 and 32 pixels for layers 1 to 3
    always_ff @(posedge clk or posedge reg_rst) begin
        if (reg_rst) begin
            tile_addr <= '0;
        end else begin
            tile_addr.scr1 <= map_addr(bases.scr1, h1, v1, 3);
            tile_addr.scr2 <= map_addr(bases.scr2, h2, v2, 4);
            tile_addr.scr3 <= map_addr(bases.scr3, h3, v3, 5);
        end
    end

endmodule

// ==== hw/cps_mmr.sv ====
/*
 * CPS-A and CPS-B register banks written from the CPU bus,
 * with byte-lane merging and per-game CPS-B offsets
 */
`timescale 1ns/1ns

module cps_mmr import cps_pkg::*; (
    input  logic         clk,
    input  logic         reg_rst,
    input  bus_wr_t      wr,
    input  logic         ppu1_cs,
    input  logic         ppu2_cs,
    input  cpsb_map_t    cpsb_map,
    output scroll_regs_t scroll,
    output base_regs_t   bases,
    output star_regs_t   stars,
    output logic [15:0]  ppu_ctrl,
    output cpsb_regs_t   cpsb
);

    // Keeps the old byte wherever its strobe is inactive
    function automatic logic [15:0] byte_merge(
        input logic [15:0] old_data,
        input logic [15:0] new_data,
        input logic [1:0]  lane_n
    );
        logic [15:0] merged;
        merged[15:8] = lane_n[1] ? old_data[15:8] : new_data[15:8];
        merged[7:0]  = lane_n[0] ? old_data[7:0]  : new_data[7:0];
        return merged;
    endfunction

    // Palette page enables live in the low byte only
    logic [15:0] pal_merge;

    assign pal_merge = byte_merge({10'd0, cpsb.pal_page_en}, wr.data, wr.dsn);

    // CPS-A bank, fixed map
    always_ff @(posedge clk or posedge reg_rst) begin
        if (reg_rst) begin
            scroll   <= '0;
            bases    <= '0;
            stars    <= '0;
            ppu_ctrl <= '0;
        end else if (ppu1_cs) begin
            case (wr.addr)
                obj_base:  bases.obj     <= byte_merge(bases.obj,     wr.data, wr.dsn);
                scr1_base: bases.scr1    <= byte_merge(bases.scr1,    wr.data, wr.dsn);
                scr2_base: bases.scr2    <= byte_merge(bases.scr2,    wr.data, wr.dsn);
                scr3_base: bases.scr3    <= byte_merge(bases.scr3,    wr.data, wr.dsn);
                row_base:  bases.row     <= byte_merge(bases.row,     wr.data, wr.dsn);
                pal_base:  bases.pal     <= byte_merge(bases.pal,     wr.data, wr.dsn);
                hpos1:     scroll.hpos1  <= byte_merge(scroll.hpos1,  wr.data, wr.dsn);
                vpos1:     scroll.vpos1  <= byte_merge(scroll.vpos1,  wr.data, wr.dsn);
                hpos2:     scroll.hpos2  <= byte_merge(scroll.hpos2,  wr.data, wr.dsn);
                vpos2:     scroll.vpos2  <= byte_merge(scroll.vpos2,  wr.data, wr.dsn);
                hpos3:     scroll.hpos3  <= byte_merge(scroll.hpos3,  wr.data, wr.dsn);
                vpos3:     scroll.vpos3  <= byte_merge(scroll.vpos3,  wr.data, wr.dsn);
                hstar1:    stars.hstar1  <= byte_merge(stars.hstar1,  wr.data, wr.dsn);
                vstar1:    stars.vstar1  <= byte_merge(stars.vstar1,  wr.data, wr.dsn);
                hstar2:    stars.hstar2  <= byte_merge(stars.hstar2,  wr.data, wr.dsn);
                vstar2:    stars.vstar2  <= byte_merge(stars.vstar2,  wr.data, wr.dsn);
                star_base: bases.star    <= byte_merge(bases.star,    wr.data, wr.dsn);
                // Port of the same name hides the enum literal here
                cps_pkg::ppu_ctrl: begin
                    ppu_ctrl <= byte_merge(ppu_ctrl, wr.data, wr.dsn);
                end
                default: begin
                    // Unmapped offsets are ignored
                end
            endcase
        end
    end

    // CPS-B bank, offsets from the per-game map.
    // Every matching field takes the write, so aliased offsets all update
    always_ff @(posedge clk or posedge reg_rst) begin
        if (reg_rst) begin
            cpsb.layer_ctrl  <= 16'h0000;
            cpsb.prio0       <= 16'hffff;
            cpsb.prio1       <= 16'hffff;
            cpsb.prio2       <= 16'hffff;
            cpsb.prio3       <= 16'hffff;
            cpsb.pal_page_en <= 6'h3f;
        end else if (ppu2_cs) begin
            if (wr.addr == cpsb_map.layer) begin
                cpsb.layer_ctrl <= byte_merge(cpsb.layer_ctrl, wr.data, wr.dsn);
            end
            if (wr.addr == cpsb_map.prio0) begin
                cpsb.prio0 <= byte_merge(cpsb.prio0, wr.data, wr.dsn);
            end
            if (wr.addr == cpsb_map.prio1) begin
                cpsb.prio1 <= byte_merge(cpsb.prio1, wr.data, wr.dsn);
            end
            if (wr.addr == cpsb_map.prio2) begin
                cpsb.prio2 <= byte_merge(cpsb.prio2, wr.data, wr.dsn);
            end
            if (wr.addr == cpsb_map.prio3) begin
                cpsb.prio3 <= byte_merge(cpsb.prio3, wr.data, wr.dsn);
            end
            if (wr.addr == cpsb_map.pal_page) begin
                cpsb.pal_page_en <= pal_merge[5:0];
            end
        end
    end

endmodule

// ==== hw/cps_video_timer.sv ====
/*
 * Free-running raster counters with a line-start pulse
 */
`timescale 1ns/1ns

module cps_video_timer import cps_pkg::*; (
    input  logic       clk,
    input  logic       reg_rst,
    output logic [8:0] hdump,
    output logic [8:0] vdump,
    output logic       line_start
);

    logic end_of_line;
    logic end_of_frame;

    assign end_of_line  = (hdump == 9'(h_total - 1));
    assign end_of_frame = (vdump == 9'(v_total - 1));

    // Pixel counter steps every clock, line counter on each wrap
    always_ff @(posedge clk or posedge reg_rst) begin
        if (reg_rst) begin
            hdump <= '0;
            vdump <= '0;
        end else if (end_of_line) begin
            hdump <= '0;
            if (end_of_frame) begin
                vdump <= '0;
            end else begin
                vdump <= vdump + 9'd1;
            end
        end else begin
            hdump <= hdump + 9'd1;
        end
    end

    // Registered from the last pixel so it lines up with hdump == 0.
    // Stays low for the reset-time zero, only real wraps raise it
    always_ff @(posedge clk or posedge reg_rst) begin
        if (reg_rst) begin
            line_start <= 1'b0;
        end else begin
            line_start <= end_of_line;
        end
    end

endmodule

// ==== hw/cps_pkg.sv ====
/*
 * Raster and map constants, CPS-A offset and layer enums, and the packed
 * structs that carry bus writes, register banks and video-side results
 */
package cps_pkg;

    // Raster size in pixels per line and lines per frame
    localparam int h_total = 512;
    localparam int v_total = 262;

    // Tiles per side of every scroll map
    localparam int map_tiles = 64;

    // CPS-A register offsets on word address bits 5:1
    typedef enum logic [4:0] {
        obj_base  = 5'h00,
        scr1_base = 5'h01,
        scr2_base = 5'h02,
        scr3_base = 5'h03,
        row_base  = 5'h04,
        pal_base  = 5'h05,
        hpos1     = 5'h06,
        vpos1     = 5'h07,
        hpos2     = 5'h08,
        vpos2     = 5'h09,
        hpos3     = 5'h0a,
        vpos3     = 5'h0b,
        hstar1    = 5'h0c,
        vstar1    = 5'h0d,
        hstar2    = 5'h0e,
        vstar2    = 5'h0f,
        star_base = 5'h10,
        ppu_ctrl  = 5'h11
    } cpsa_reg_t;

    // Layer codes as packed in the layer control word
    typedef enum logic [1:0] {
        obj  = 2'd0,
        scr1 = 2'd1,
        scr2 = 2'd2,
        scr3 = 2'd3
    } layer_id_t;

    // One CPU write cycle
    typedef struct packed {
        logic [4:0]  addr;
        logic [1:0]  dsn;   // bit 1 upper byte, bit 0 lower byte, active low
        logic [15:0] data;
    } bus_wr_t;

    // Per-game CPS-B register offsets
    typedef struct packed {
        logic [4:0] layer;
        logic [4:0] prio0;
        logic [4:0] prio1;
        logic [4:0] prio2;
        logic [4:0] prio3;
        logic [4:0] pal_page;
    } cpsb_map_t;

    typedef struct packed {
        logic [15:0] hpos1;
        logic [15:0] vpos1;
        logic [15:0] hpos2;
        logic [15:0] vpos2;
        logic [15:0] hpos3;
        logic [15:0] vpos3;
    } scroll_regs_t;

    // VRAM base pointers
    typedef struct packed {
        logic [15:0] obj;
        logic [15:0] scr1;
        logic [15:0] scr2;
        logic [15:0] scr3;
        logic [15:0] row;
        logic [15:0] star;
        logic [15:0] pal;
    } base_regs_t;

    typedef struct packed {
        logic [15:0] hstar1;
        logic [15:0] vstar1;
        logic [15:0] hstar2;
        logic [15:0] vstar2;
    } star_regs_t;

    typedef struct packed {
        logic [15:0] layer_ctrl;
        logic [15:0] prio0;
        logic [15:0] prio1;
        logic [15:0] prio2;
        logic [15:0] prio3;
        logic [5:0]  pal_page_en;
    } cpsb_regs_t;

    // Tile map word address per scroll layer
    typedef struct packed {
        logic [15:0] scr1;
        logic [15:0] scr2;
        logic [15:0] scr3;
    } tile_addr_t;

    // draw0 is drawn first, draw3 last
    typedef struct packed {
        layer_id_t  draw0;
        layer_id_t  draw1;
        layer_id_t  draw2;
        layer_id_t  draw3;
        logic [4:0] en;
    } draw_order_t;

endpackage
